/* hw/bpu_pkg.sv */
`include "ftq_consts.svh"

package bpu_pkg;

    // where the target sits relative to the branch pc upper bits
    typedef enum logic [1:0] {
        FIT,
        OVF,
        UDF
    } tar_stat_e;

    typedef enum logic [1:0] {
        COND,
        JUMP,
        CALL,
        RET
    } branch_type_e;

    // compressed btb entry update
    typedef struct packed {
        logic                        carry;
        logic [`FTB_FALLTHRU_W-1:0]  fallthru_addr;
        tar_stat_e                   tar_stat;
        logic [`FTB_TARGET_W-1:0]    target_addr;
        branch_type_e                branch_type;
    } ftb_update_t;

    typedef struct packed {
        logic [`ADDR_W-1:0] start_addr;
        ftb_update_t        ftb_update;
    } bpu_update_t;

    // commit/update sequencer
    typedef enum logic [1:0] {
        IDLE,
        REQ,
        RELEASE
    } commit_state_e;

endpackage

/* hw/frontend_pkg.sv */
`include "ftq_consts.svh"

package frontend_pkg;

    import bpu_pkg::*;

    typedef logic [`FTQ_IDX_W-1:0] ftq_idx_t;

    // wide enough to hold MAX_FETCH_BYTES itself
    typedef logic [$clog2(`MAX_FETCH_BYTES):0] fetch_size_t;

    // block from the predictor
    typedef struct packed {
        logic [`ADDR_W-1:0] start_addr;
        logic [`ADDR_W-1:0] end_addr;
    } ftq_info_t;

    // one resolved branch from the backend
    typedef struct packed {
        ftq_idx_t           ftq_idx;
        logic [`ADDR_W-1:0] branch_pc;
        logic [`ADDR_W-1:0] fallthru_addr;
        logic [`ADDR_W-1:0] target_addr;
        logic               taken;
        logic               mispred;
        branch_type_e       branch_type;
    } branch_wb_t;

    // stored entry, block fields plus branch fields
    typedef struct packed {
        logic [`ADDR_W-1:0] start_addr;
        logic [`ADDR_W-1:0] end_addr;
        logic [`ADDR_W-1:0] branch_pc;
        logic [`ADDR_W-1:0] fallthru_addr;
        logic [`ADDR_W-1:0] target_addr;
        logic               taken;
        logic               mispred;
        branch_type_e       branch_type;
    } ftq_entry_t;

    typedef struct packed {
        logic [`ADDR_W-1:0] start_addr;
        fetch_size_t        block_size;
    } fetch_info_t;

endpackage

/* hw/ftb_update_enc.sv */
`timescale 1ns/1ps
`include "ftq_consts.svh"

module ftb_update_enc
    import frontend_pkg::*, bpu_pkg::*;
(
    input  ftq_entry_t  i_entry,
    output bpu_update_t o_update
);

    localparam int FW = `FTB_FALLTHRU_W;
    localparam int TW = `FTB_TARGET_W;

    // three bits just above the kept field
    logic [2:0] ft_hi;
    logic [2:0] ft_pc_hi;
    logic [2:0] tg_hi;
    logic [2:0] tg_pc_hi;

    assign ft_hi    = i_entry.fallthru_addr[FW+3:FW+1];
    assign ft_pc_hi = i_entry.branch_pc[FW+3:FW+1];
    assign tg_hi    = i_entry.target_addr[TW+3:TW+1];
    assign tg_pc_hi = i_entry.branch_pc[TW+3:TW+1];

    always_comb begin
        o_update.start_addr               = i_entry.start_addr;
        o_update.ftb_update.carry         = (ft_hi > ft_pc_hi);
        // bit 0 is always zero for aligned pcs
        o_update.ftb_update.fallthru_addr = i_entry.fallthru_addr[FW:1];
        o_update.ftb_update.target_addr   = i_entry.target_addr[TW:1];
        o_update.ftb_update.branch_type   = i_entry.branch_type;

        if (tg_hi == tg_pc_hi) begin
            o_update.ftb_update.tar_stat = FIT;
        end else if (tg_hi > tg_pc_hi) begin
            o_update.ftb_update.tar_stat = OVF;
        end else begin
            o_update.ftb_update.tar_stat = UDF;
        end
    end

endmodule

/* hw/ftq_commit_fsm.sv */
`timescale 1ns/1ps

module ftq_commit_fsm
    import frontend_pkg::*, bpu_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     i_commit_vld,
    input  ftq_idx_t i_commit_idx,
    input  ftq_idx_t i_commit_ptr,
    input  logic     i_bpu_ack,
    output logic     o_bpu_req,
    output logic     o_commit_adv
);

    commit_state_e state;
    commit_state_e state_nxt;

    // everything before this index is committed
    ftq_idx_t commit_thre;

    always_ff @(posedge clk) begin
        if (rst) begin
            commit_thre <= '0;
        end else if (i_commit_vld) begin
            commit_thre <= i_commit_idx;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (i_commit_ptr != commit_thre) begin
                    state_nxt = REQ;
                end
            end
            // hold req until the predictor acks
            REQ: begin
                if (i_bpu_ack) begin
                    state_nxt = RELEASE;
                end
            end
            // wait for ack to drop before the next update
            RELEASE: begin
                if (!i_bpu_ack) begin
                    state_nxt = IDLE;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    assign o_bpu_req    = (state == REQ);
    assign o_commit_adv = (state == RELEASE) && !i_bpu_ack;

endmodule

/* hw/ftq_consts.svh */
`ifndef FTQ_CONSTS_SVH
`define FTQ_CONSTS_SVH

// queue geometry
`define FTQ_SIZE 8
`define FTQ_IDX_W 3

// fetch addresses
`define ADDR_W 32

// compressed btb fields, bits kept above bit 0
`define FTB_FALLTHRU_W 4
`define FTB_TARGET_W 12

// largest block the icache takes in one request
`define MAX_FETCH_BYTES 64

`endif

/* hw/ftq_entry_ram.sv */
`timescale 1ns/1ps
`include "ftq_consts.svh"

module ftq_entry_ram
    import frontend_pkg::*;
(
    input  logic        clk,
    input  logic        i_push,
    input  ftq_idx_t    i_push_ptr,
    input  ftq_info_t   i_push_info,
    input  logic        i_wb_vld,
    input  branch_wb_t  i_wb,
    input  ftq_idx_t    i_fetch_ptr,
    input  ftq_idx_t    i_commit_ptr,
    output fetch_info_t o_fetch_info,
    output ftq_entry_t  o_commit_entry
);

    localparam int SIZE_W = $bits(fetch_size_t);

    ftq_entry_t mem [`FTQ_SIZE];

    ftq_entry_t         fetch_entry;
    logic [`ADDR_W-1:0] span;

    // block and branch fields are written independently
    always_ff @(posedge clk) begin
        if (i_push) begin
            mem[i_push_ptr].start_addr <= i_push_info.start_addr;
            mem[i_push_ptr].end_addr   <= i_push_info.end_addr;
        end
        if (i_wb_vld) begin
            mem[i_wb.ftq_idx].branch_pc     <= i_wb.branch_pc;
            mem[i_wb.ftq_idx].fallthru_addr <= i_wb.fallthru_addr;
            mem[i_wb.ftq_idx].target_addr   <= i_wb.target_addr;
            mem[i_wb.ftq_idx].taken         <= i_wb.taken;
            mem[i_wb.ftq_idx].mispred       <= i_wb.mispred;
            mem[i_wb.ftq_idx].branch_type   <= i_wb.branch_type;
        end
    end

    assign fetch_entry = mem[i_fetch_ptr];
    assign span        = fetch_entry.end_addr - fetch_entry.start_addr;

    // icache request for the oldest unfetched block
    always_comb begin
        o_fetch_info.start_addr = fetch_entry.start_addr;
        o_fetch_info.block_size = span[SIZE_W-1:0];
    end

    assign o_commit_entry = mem[i_commit_ptr];

endmodule

/* hw/ftq_ptr_ctr.sv */
`timescale 1ns/1ps
`include "ftq_consts.svh"

module ftq_ptr_ctr
    import frontend_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     i_push,
    input  logic     i_fetch_adv,
    input  logic     i_commit_adv,
    output ftq_idx_t o_pred_ptr,
    output ftq_idx_t o_fetch_ptr,
    output ftq_idx_t o_commit_ptr,
    output logic     o_full,
    output logic     o_fetch_pending
);

    localparam ftq_idx_t LAST_IDX = ftq_idx_t'(`FTQ_SIZE - 1);
    localparam logic [`FTQ_IDX_W:0] FULL_CNT = (`FTQ_IDX_W + 1)'(`FTQ_SIZE);

    // entries held between commit and predict
    logic [`FTQ_IDX_W:0] occ;
    // entries pushed but not yet sent to the icache
    logic [`FTQ_IDX_W:0] unfetched;

    function automatic ftq_idx_t next_ptr(input ftq_idx_t p);
        return (p == LAST_IDX) ? '0 : p + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            o_pred_ptr   <= '0;
            o_fetch_ptr  <= '0;
            o_commit_ptr <= '0;
            occ          <= '0;
            unfetched    <= '0;
        end else begin
            if (i_push) begin
                o_pred_ptr <= next_ptr(o_pred_ptr);
            end
            if (i_fetch_adv) begin
                o_fetch_ptr <= next_ptr(o_fetch_ptr);
            end
            if (i_commit_adv) begin
                o_commit_ptr <= next_ptr(o_commit_ptr);
            end

            // push and free may land on the same edge
            case ({i_push, i_commit_adv})
                2'b10:   occ <= occ + 1'b1;
                2'b01:   occ <= occ - 1'b1;
                default: occ <= occ;
            endcase

            case ({i_push, i_fetch_adv})
                2'b10:   unfetched <= unfetched + 1'b1;
                2'b01:   unfetched <= unfetched - 1'b1;
                default: unfetched <= unfetched;
            endcase
        end
    end

    assign o_full          = (occ == FULL_CNT);
    // pred == fetch alone is ambiguous when the queue is full
    assign o_fetch_pending = (unfetched != '0);

endmodule

/* hw/ftq_top.sv */
`timescale 1ns/1ps

module ftq_top
    import frontend_pkg::*, bpu_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    // predictor push
    input  logic        i_pred_vld,
    input  ftq_info_t   i_pred_info,
    output logic        o_pred_rdy,
    // icache fetch
    output logic        o_fetch_vld,
    output fetch_info_t o_fetch_info,
    input  logic        i_fetch_rdy,
    // backend writeback and commit
    input  logic        i_wb_vld,
    input  branch_wb_t  i_wb,
    input  logic        i_commit_vld,
    input  ftq_idx_t    i_commit_idx,
    // predictor update
    output logic        o_bpu_req,
    output bpu_update_t o_bpu_update,
    input  logic        i_bpu_ack
);

    ftq_idx_t   pred_ptr;
    ftq_idx_t   fetch_ptr;
    ftq_idx_t   commit_ptr;
    logic       full;
    logic       fetch_pending;
    logic       push;
    logic       fetch_adv;
    logic       commit_adv;
    ftq_entry_t commit_entry;

    assign o_pred_rdy  = !full;
    assign o_fetch_vld = fetch_pending;
    assign push        = i_pred_vld && o_pred_rdy;
    assign fetch_adv   = o_fetch_vld && i_fetch_rdy;

    ftq_ptr_ctr u_ptr_ctr (
        .clk             (clk),
        .rst             (rst),
        .i_push          (push),
        .i_fetch_adv     (fetch_adv),
        .i_commit_adv    (commit_adv),
        .o_pred_ptr      (pred_ptr),
        .o_fetch_ptr     (fetch_ptr),
        .o_commit_ptr    (commit_ptr),
        .o_full          (full),
        .o_fetch_pending (fetch_pending)
    );

    ftq_entry_ram u_entry_ram (
        .clk            (clk),
        .i_push         (push),
        .i_push_ptr     (pred_ptr),
        .i_push_info    (i_pred_info),
        .i_wb_vld       (i_wb_vld),
        .i_wb           (i_wb),
        .i_fetch_ptr    (fetch_ptr),
        .i_commit_ptr   (commit_ptr),
        .o_fetch_info   (o_fetch_info),
        .o_commit_entry (commit_entry)
    );

    ftb_update_enc u_update_enc (
        .i_entry  (commit_entry),
        .o_update (o_bpu_update)
    );

    ftq_commit_fsm u_commit_fsm (
        .clk          (clk),
        .rst          (rst),
        .i_commit_vld (i_commit_vld),
        .i_commit_idx (i_commit_idx),
        .i_commit_ptr (commit_ptr),
        .i_bpu_ack    (i_bpu_ack),
        .o_bpu_req    (o_bpu_req),
        .o_commit_adv (commit_adv)
    );

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the ftq testbench with verilator, then scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module ftq_tb -f src.f -o ftq_sim \
    > build.log 2>&1 \
    || { cat build.log; echo "verilator build failed"; exit 1; }
./obj_dir/ftq_sim > sim.log 2>&1 \
    || { cat sim.log; echo "simulation stopped with an error"; exit 1; }
cat sim.log
grep -q "SOME TESTS FAILED" sim.log && { echo "simulation reported failures"; exit 1; }
exit 0

/* src.f */
+incdir+hw
hw/bpu_pkg.sv
hw/frontend_pkg.sv
hw/ftq_ptr_ctr.sv
hw/ftq_entry_ram.sv
hw/ftb_update_enc.sv
hw/ftq_commit_fsm.sv
hw/ftq_top.sv
verif/ftq_props.sv
verif/ftq_tb.sv

/* verif/ftq_props.sv */
`timescale 1ns/1ps
`include "ftq_consts.svh"

module ftq_props
    import frontend_pkg::*, bpu_pkg::*;
(
    input logic        clk,
    input logic        rst,
    input logic        i_bpu_ack,
    input logic        o_bpu_req,
    input bpu_update_t o_bpu_update,
    input logic        o_fetch_vld,
    input fetch_info_t o_fetch_info
);

    // update payload frozen for the whole request phase
    update_stable: assert property (@(posedge clk) disable iff (rst)
        o_bpu_req |=> (!o_bpu_req || $stable(o_bpu_update)))
        else $error("o_bpu_update changed while o_bpu_req was high");

    // four-phase: a new request only after ack has dropped
    req_after_ack_low: assert property (@(posedge clk) disable iff (rst)
        $rose(o_bpu_req) |-> !i_bpu_ack)
        else $error("o_bpu_req rose while i_bpu_ack was high");

    fetch_size_legal: assert property (@(posedge clk) disable iff (rst)
        o_fetch_vld |-> (o_fetch_info.block_size >= fetch_size_t'(1) &&
                         o_fetch_info.block_size <= fetch_size_t'(`MAX_FETCH_BYTES)))
        else $error("fetch block size out of range");

endmodule

bind ftq_top ftq_props u_props (
    .clk          (clk),
    .rst          (rst),
    .i_bpu_ack    (i_bpu_ack),
    .o_bpu_req    (o_bpu_req),
    .o_bpu_update (o_bpu_update),
    .o_fetch_vld  (o_fetch_vld),
    .o_fetch_info (o_fetch_info)
);

/* verif/ftq_stimulus.txt */
# start end branch_pc target fallthru btype exp_size exp_carry exp_stat (all hex)
# btype 0 COND 1 JUMP 2 CALL 3 RET, stat 0 FIT 1 OVF 2 UDF
00001000 00001020 0000101c 00001200 00001020 0 20 1 0
00001020 00001040 00001028 00004000 0000102c 1 20 0 1
00005000 00005010 0000500c 00001000 00005010 2 10 0 2
00005010 00005050 00005048 00005800 00005050 3 40 0 0
000080e0 000080e4 000080e2 0000a000 00008104 0 04 0 1
0000c000 0000c001 0000c000 0000c0f0 0000c0a0 1 01 1 0
00010000 00010030 0001e010 00010100 0001e0c0 2 30 1 2
00020000 00020008 00020004 00026000 00020008 3 08 0 1
00030000 00030040 00030010 00030020 00030014 0 40 0 0

/* verif/ftq_tb.sv */
`timescale 1ns/1ps
`include "ftq_consts.svh"

module ftq_tb
    import frontend_pkg::*, bpu_pkg::*;
();

    localparam int TIMEOUT = 200;
    localparam int NUM_REC = 9;

    // one line of the stimulus file
    typedef struct packed {
        logic [`ADDR_W-1:0] start_addr;
        logic [`ADDR_W-1:0] end_addr;
        logic [`ADDR_W-1:0] branch_pc;
        logic [`ADDR_W-1:0] target_addr;
        logic [`ADDR_W-1:0] fallthru_addr;
        branch_type_e       branch_type;
        fetch_size_t        block_size;
        logic               carry;
        tar_stat_e          tar_stat;
    } stim_rec_t;

    stim_rec_t recs [NUM_REC];

    logic        clk;
    logic        rst;
    logic        i_pred_vld;
    ftq_info_t   i_pred_info;
    logic        o_pred_rdy;
    logic        o_fetch_vld;
    fetch_info_t o_fetch_info;
    logic        i_fetch_rdy;
    logic        i_wb_vld;
    branch_wb_t  i_wb;
    logic        i_commit_vld;
    ftq_idx_t    i_commit_idx;
    logic        o_bpu_req;
    bpu_update_t o_bpu_update;
    logic        i_bpu_ack;

    int          errors;
    int          checks;
    logic        aborted;
    logic [31:0] lfsr_state;

    ftq_top UUT (
        .clk          (clk),
        .rst          (rst),
        .i_pred_vld   (i_pred_vld),
        .i_pred_info  (i_pred_info),
        .o_pred_rdy   (o_pred_rdy),
        .o_fetch_vld  (o_fetch_vld),
        .o_fetch_info (o_fetch_info),
        .i_fetch_rdy  (i_fetch_rdy),
        .i_wb_vld     (i_wb_vld),
        .i_wb         (i_wb),
        .i_commit_vld (i_commit_vld),
        .i_commit_idx (i_commit_idx),
        .o_bpu_req    (o_bpu_req),
        .o_bpu_update (o_bpu_update),
        .i_bpu_ack    (i_bpu_ack)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // galois lfsr, x^32 + x^22 + x^2 + x + 1
    function automatic logic next_rand_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = (lfsr_state >> 1) ^ (out ? 32'h8020_0003 : 32'h0);
        return out;
    endfunction

    function automatic int rand_delay();
        int d;
        d = 2 * int'(next_rand_bit());
        d = d + int'(next_rand_bit());
        return d;
    endfunction

    // kept fields drop bit 0 of each address
    function automatic bpu_update_t expected_update(input stim_rec_t r);
        bpu_update_t u;
        u.start_addr               = r.start_addr;
        u.ftb_update.carry         = r.carry;
        u.ftb_update.fallthru_addr = r.fallthru_addr[`FTB_FALLTHRU_W:1];
        u.ftb_update.tar_stat      = r.tar_stat;
        u.ftb_update.target_addr   = r.target_addr[`FTB_TARGET_W:1];
        u.ftb_update.branch_type   = r.branch_type;
        return u;
    endfunction

    task automatic report_timeout(input string what);
        $display("timeout while waiting for %s at %0t", what, $time);
        aborted = 1'b1;
    endtask

    task automatic check_fetch(input fetch_info_t got, input fetch_info_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: fetch start %h size %0d, expected start %h size %0d",
                     $time, got.start_addr, got.block_size, exp.start_addr, exp.block_size);
        end
    endtask

    task automatic check_update(input bpu_update_t got, input bpu_update_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: bpu update %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic load_stimulus();
        int          fd;
        int          n;
        int          cnt;
        string       line;
        logic [31:0] fld [9];
        fd = $fopen("verif/ftq_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file verif/ftq_stimulus.txt");
            aborted = 1'b1;
            return;
        end
        cnt = 0;
        while (!$feof(fd) && cnt < NUM_REC) begin
            line = "";
            n = $fgets(line, fd);
            // skip the column description lines
            if (n > 0 && line.len() > 1 && line[0] != "#") begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h", fld[0], fld[1], fld[2],
                            fld[3], fld[4], fld[5], fld[6], fld[7], fld[8]);
                if (n == 9) begin
                    recs[cnt].start_addr    = fld[0];
                    recs[cnt].end_addr      = fld[1];
                    recs[cnt].branch_pc     = fld[2];
                    recs[cnt].target_addr   = fld[3];
                    recs[cnt].fallthru_addr = fld[4];
                    recs[cnt].branch_type   = branch_type_e'(fld[5][1:0]);
                    recs[cnt].block_size    = fetch_size_t'(fld[6]);
                    recs[cnt].carry         = fld[7][0];
                    recs[cnt].tar_stat      = tar_stat_e'(fld[8][1:0]);
                    cnt++;
                end
            end
        end
        $fclose(fd);
        if (cnt != NUM_REC) begin
            $display("stimulus file holds %0d records, %0d were needed", cnt, NUM_REC);
            aborted = 1'b1;
        end
    endtask

    task automatic push_blocks(input int first, input int count);
        int wait_cnt;
        for (int i = first; i < first + count; i++) begin
            wait_cnt = 0;
            while (!o_pred_rdy && wait_cnt < TIMEOUT) begin
                @(negedge clk);
                wait_cnt++;
            end
            if (!o_pred_rdy) begin
                report_timeout("o_pred_rdy");
                return;
            end
            i_pred_vld             = 1'b1;
            i_pred_info.start_addr = recs[i].start_addr;
            i_pred_info.end_addr   = recs[i].end_addr;
            @(negedge clk);
            i_pred_vld = 1'b0;
        end
    endtask

    // random icache stalls, request checked every cycle it is offered
    task automatic drain_fetch(input int first, input int count);
        int          got;
        int          cycles;
        logic        rdy;
        fetch_info_t exp;
        got    = 0;
        cycles = 0;
        while (got < count && cycles < TIMEOUT) begin
            rdy = next_rand_bit();
            if (o_fetch_vld) begin
                exp.start_addr = recs[first + got].start_addr;
                exp.block_size = recs[first + got].block_size;
                check_fetch(o_fetch_info, exp);
                if (rdy) begin
                    got++;
                end
            end
            i_fetch_rdy = rdy;
            @(negedge clk);
            cycles++;
        end
        i_fetch_rdy = 1'b0;
        if (got < count) begin
            report_timeout("fetch requests");
        end
    endtask

    task automatic write_back(input int idx);
        i_wb_vld           = 1'b1;
        i_wb.ftq_idx       = ftq_idx_t'(idx);
        i_wb.branch_pc     = recs[idx].branch_pc;
        i_wb.fallthru_addr = recs[idx].fallthru_addr;
        i_wb.target_addr   = recs[idx].target_addr;
        i_wb.taken         = 1'b1;
        i_wb.mispred       = 1'b0;
        i_wb.branch_type   = recs[idx].branch_type;
        @(negedge clk);
        i_wb_vld = 1'b0;
    endtask

    task automatic issue_commit(input int idx);
        i_commit_vld = 1'b1;
        i_commit_idx = ftq_idx_t'(idx);
        @(negedge clk);
        i_commit_vld = 1'b0;
    endtask

    task automatic expect_no_update(input int cycles);
        repeat (cycles) begin
            check_flag(o_bpu_req, 1'b0, "o_bpu_req with nothing to commit");
            @(negedge clk);
        end
    endtask

    // four-phase req/ack with random ack latency on both edges
    task automatic run_updates(input int first, input int count);
        int          wait_cnt;
        bpu_update_t exp;
        for (int k = 0; k < count; k++) begin
            wait_cnt = 0;
            while (!o_bpu_req && wait_cnt < TIMEOUT) begin
                @(negedge clk);
                wait_cnt++;
            end
            if (!o_bpu_req) begin
                report_timeout("o_bpu_req to rise");
                return;
            end
            exp = expected_update(recs[first + k]);
            check_update(o_bpu_update, exp);
            repeat (rand_delay()) begin
                @(negedge clk);
                check_flag(o_bpu_req, 1'b1, "o_bpu_req before ack");
                check_update(o_bpu_update, exp);
            end
            i_bpu_ack = 1'b1;
            wait_cnt  = 0;
            while (o_bpu_req && wait_cnt < TIMEOUT) begin
                @(negedge clk);
                wait_cnt++;
            end
            if (o_bpu_req) begin
                report_timeout("o_bpu_req to fall");
                return;
            end
            repeat (rand_delay()) @(negedge clk);
            i_bpu_ack = 1'b0;
            @(negedge clk);
        end
    endtask

    task automatic exercise_queue();
        check_flag(o_fetch_vld, 1'b0, "o_fetch_vld after reset");
        check_flag(o_bpu_req, 1'b0, "o_bpu_req after reset");
        check_flag(o_pred_rdy, 1'b1, "o_pred_rdy after reset");

        // fill the queue while the icache drains it
        fork
            push_blocks(0, `FTQ_SIZE);
            drain_fetch(0, `FTQ_SIZE);
        join
        if (aborted) return;

        // full, so a held push must be refused
        i_pred_vld             = 1'b1;
        i_pred_info.start_addr = recs[8].start_addr;
        i_pred_info.end_addr   = recs[8].end_addr;
        repeat (4) begin
            check_flag(o_pred_rdy, 1'b0, "o_pred_rdy on a full queue");
            check_flag(o_fetch_vld, 1'b0, "o_fetch_vld after a refused push");
            check_flag(o_bpu_req, 1'b0, "o_bpu_req before commit");
            @(negedge clk);
        end
        i_pred_vld = 1'b0;

        for (int i = 0; i < `FTQ_SIZE; i++) begin
            write_back(i);
        end
        expect_no_update(4);

        // one update frees exactly one slot
        issue_commit(1);
        run_updates(0, 1);
        if (aborted) return;
        expect_no_update(6);
        check_flag(o_pred_rdy, 1'b1, "o_pred_rdy after one update");
        push_blocks(8, 1);
        if (aborted) return;
        check_flag(o_pred_rdy, 1'b0, "o_pred_rdy after refill");
        drain_fetch(8, 1);
        if (aborted) return;

        issue_commit(5);
        run_updates(1, 4);
        if (aborted) return;
        expect_no_update(6);

        // threshold wraps back to entry 0
        issue_commit(0);
        run_updates(5, 3);
        if (aborted) return;
        expect_no_update(6);
        check_flag(o_pred_rdy, 1'b1, "o_pred_rdy after drain");
    endtask

    initial begin
        errors       = 0;
        checks       = 0;
        aborted      = 1'b0;
        lfsr_state   = 32'he30;
        rst          = 1'b1;
        i_pred_vld   = 1'b0;
        i_pred_info  = '0;
        i_fetch_rdy  = 1'b0;
        i_wb_vld     = 1'b0;
        i_wb         = '0;
        i_commit_vld = 1'b0;
        i_commit_idx = '0;
        i_bpu_ack    = 1'b0;
        load_stimulus();

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        if (!aborted) begin
            exercise_queue();
        end

        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0 && !aborted) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
